/* logic/rv32_isa_pkg.sv */
`default_nettype none

package rv32_isa_pkg;

  localparam int XLEN = 32;
  localparam int REG_BITS = 5;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [REG_BITS-1:0] reg_addr_t;
  typedef logic [31:0] inst_t;

  // Major opcodes, taken from bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // Arithmetic funct3 codes, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Branch funct3 codes
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam xlen_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

/* logic/rv32_mem_map_pkg.sv */
`default_nettype none

package rv32_mem_map_pkg;

  localparam int HALF_BITS = 16;
  localparam int ADDR_BITS = 32;

  typedef logic [HALF_BITS-1:0] half_t;
  typedef logic [ADDR_BITS-1:0] bus_addr_t;

  // External SRAM holds 64K halfwords, so 128 KiB of byte addresses
  localparam bus_addr_t SRAM_BASE = 32'h0000_0000;
  localparam bus_addr_t SRAM_END  = 32'h0001_FFFF;

  // Only the low half of a word store lands in the output register
  localparam bus_addr_t GPIO_ADDR = 32'h0002_0000;

  typedef enum logic [1:0] {
    REG_SRAM,
    REG_GPIO,
    REG_NONE
  } region_t;

endpackage

`default_nettype wire

/* logic/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Four-phase req/ack bus moving one halfword per transfer
interface mem_bus_if;

  logic                        req;
  logic                        we;
  rv32_mem_map_pkg::bus_addr_t addr;
  rv32_mem_map_pkg::half_t     wdata;
  logic                        ack;
  rv32_mem_map_pkg::half_t     rdata;

  modport master (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport slave (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

`default_nettype wire

/* logic/rv32_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_regfile (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    we_i,
  input  rv32_isa_pkg::reg_addr_t rd_addr_i,
  input  rv32_isa_pkg::xlen_t     rd_data_i,
  input  rv32_isa_pkg::reg_addr_t rs1_addr_i,
  input  rv32_isa_pkg::reg_addr_t rs2_addr_i,
  output rv32_isa_pkg::xlen_t     rs1_o,
  output rv32_isa_pkg::xlen_t     rs2_o
);

  // x0 has no storage behind it
  rv32_isa_pkg::xlen_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_addr_i != '0)) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  assign rs1_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* logic/rv32_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_alu (
  input  rv32_isa_pkg::alu_op_t op_i,
  input  rv32_isa_pkg::xlen_t   a_i,
  input  rv32_isa_pkg::xlen_t   b_i,
  output rv32_isa_pkg::xlen_t   result_o,
  output logic                  equal_o,
  output logic                  less_o,
  output logic                  less_signed_o
);

  // Compare flags are always valid, whatever op_i selects
  assign equal_o       = (a_i == b_i);
  assign less_o        = (a_i < b_i);
  assign less_signed_o = ($signed(a_i) < $signed(b_i));

  always_comb begin
    case (op_i)
      rv32_isa_pkg::ALU_ADD:  result_o = a_i + b_i;
      rv32_isa_pkg::ALU_SUB:  result_o = a_i - b_i;
      rv32_isa_pkg::ALU_AND:  result_o = a_i & b_i;
      rv32_isa_pkg::ALU_OR:   result_o = a_i | b_i;
      rv32_isa_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      rv32_isa_pkg::ALU_SLT:  result_o = rv32_isa_pkg::xlen_t'(less_signed_o);
      rv32_isa_pkg::ALU_SLTU: result_o = rv32_isa_pkg::xlen_t'(less_o);
      default:                result_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

/* logic/rv32_control.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_control (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  mem_bus_if.master               bus,
  output rv32_isa_pkg::reg_addr_t rs1_addr_o,
  output rv32_isa_pkg::reg_addr_t rs2_addr_o,
  output rv32_isa_pkg::reg_addr_t rd_addr_o,
  output logic                    rd_we_o,
  output rv32_isa_pkg::xlen_t     rd_data_o,
  input  rv32_isa_pkg::xlen_t     rs1_i,
  input  rv32_isa_pkg::xlen_t     rs2_i,
  output rv32_isa_pkg::alu_op_t   alu_op_o,
  output rv32_isa_pkg::xlen_t     alu_b_o,
  input  rv32_isa_pkg::xlen_t     alu_result_i,
  input  logic                    alu_equal_i,
  input  logic                    alu_less_i,
  input  logic                    alu_less_signed_i,
  output logic                    halted_o
);

  typedef enum logic [2:0] {
    FETCH_LO, FETCH_HI, DECODE, MEM_LO, MEM_HI, EXECUTE, HALT
  } state_t;

  state_t                 state_q;
  rv32_isa_pkg::xlen_t    pc_q;
  logic                   req_q;
  rv32_isa_pkg::inst_t    ir_q;
  rv32_isa_pkg::xlen_t    load_q;
  rv32_isa_pkg::opcode_t  opcode;
  logic [2:0]             funct3;
  rv32_isa_pkg::xlen_t    imm_i;
  rv32_isa_pkg::xlen_t    imm_s;
  rv32_isa_pkg::xlen_t    imm_b;
  rv32_isa_pkg::xlen_t    imm_j;
  rv32_isa_pkg::xlen_t    eff_addr;
  rv32_isa_pkg::xlen_t    next_pc;
  logic                   in_access;
  logic                   done;
  logic                   taken;
  logic                   wb_en;

  //////////////////////////////////////////////////////////////////////
  // Decode

  assign opcode = rv32_isa_pkg::opcode_t'(ir_q[6:0]);
  assign funct3 = ir_q[14:12];
  assign rs1_addr_o = ir_q[19:15];
  assign rs2_addr_o = ir_q[24:20];
  assign rd_addr_o  = ir_q[11:7];

  assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
  assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
  assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
  assign imm_j = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

  // SUB exists only in the register-register form, OP-IMM has no funct7
  always_comb begin
    alu_b_o  = (opcode == rv32_isa_pkg::OP_IMM) ? imm_i : rs2_i;
    alu_op_o = rv32_isa_pkg::ALU_ADD;
    case (funct3)
      rv32_isa_pkg::F3_ADD: begin
        if (opcode == rv32_isa_pkg::OP && ir_q[30]) begin
          alu_op_o = rv32_isa_pkg::ALU_SUB;
        end
      end
      rv32_isa_pkg::F3_SLT:  alu_op_o = rv32_isa_pkg::ALU_SLT;
      rv32_isa_pkg::F3_SLTU: alu_op_o = rv32_isa_pkg::ALU_SLTU;
      rv32_isa_pkg::F3_XOR:  alu_op_o = rv32_isa_pkg::ALU_XOR;
      rv32_isa_pkg::F3_OR:   alu_op_o = rv32_isa_pkg::ALU_OR;
      rv32_isa_pkg::F3_AND:  alu_op_o = rv32_isa_pkg::ALU_AND;
      default:               alu_op_o = rv32_isa_pkg::ALU_ADD;
    endcase
  end

  // Branches compare rs1 with rs2 through the ALU flags
  always_comb begin
    case (funct3)
      rv32_isa_pkg::F3_BEQ:  taken = alu_equal_i;
      rv32_isa_pkg::F3_BNE:  taken = !alu_equal_i;
      rv32_isa_pkg::F3_BLT:  taken = alu_less_signed_i;
      rv32_isa_pkg::F3_BGE:  taken = !alu_less_signed_i;
      rv32_isa_pkg::F3_BLTU: taken = alu_less_i;
      rv32_isa_pkg::F3_BGEU: taken = !alu_less_i;
      default:               taken = 1'b0;
    endcase
  end

  always_comb begin
    next_pc = pc_q + 32'd4;
    if (opcode == rv32_isa_pkg::JAL) begin
      next_pc = pc_q + imm_j;
    end else if (opcode == rv32_isa_pkg::BRANCH && taken) begin
      next_pc = pc_q + imm_b;
    end
  end

  always_comb begin
    wb_en     = 1'b1;
    rd_data_o = alu_result_i;
    case (opcode)
      rv32_isa_pkg::OP, rv32_isa_pkg::OP_IMM: rd_data_o = alu_result_i;
      rv32_isa_pkg::LUI:  rd_data_o = {ir_q[31:12], 12'b0};
      rv32_isa_pkg::LOAD: rd_data_o = load_q;
      rv32_isa_pkg::JAL:  rd_data_o = pc_q + 32'd4;
      default:            wb_en = 1'b0;
    endcase
  end

  assign rd_we_o  = (state_q == EXECUTE) && wb_en;
  assign halted_o = (state_q == HALT);

  //////////////////////////////////////////////////////////////////////
  // Memory bus

  assign in_access = state_q inside {FETCH_LO, FETCH_HI, MEM_LO, MEM_HI};
  assign done      = req_q && bus.ack;
  assign eff_addr  = rs1_i + ((opcode == rv32_isa_pkg::STORE) ? imm_s : imm_i);

  assign bus.req   = req_q;
  assign bus.we    = (state_q inside {MEM_LO, MEM_HI}) && (opcode == rv32_isa_pkg::STORE);
  assign bus.wdata = (state_q == MEM_HI) ? rs2_i[31:16] : rs2_i[15:0];

  // Low half first, high half at the next halfword address
  always_comb begin
    case (state_q)
      FETCH_HI: bus.addr = pc_q + 32'd2;
      MEM_LO:   bus.addr = eff_addr;
      MEM_HI:   bus.addr = eff_addr + 32'd2;
      default:  bus.addr = pc_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH_LO;
      pc_q    <= rv32_isa_pkg::RESET_PC;
      req_q   <= 1'b0;
    end else begin
      // A new request waits until the previous ack has fallen
      if (in_access && !req_q && !bus.ack) begin
        req_q <= 1'b1;
      end else if (done) begin
        req_q <= 1'b0;
      end
      case (state_q)
        FETCH_LO: if (done) state_q <= FETCH_HI;
        FETCH_HI: if (done) state_q <= DECODE;
        DECODE: begin
          if (opcode == rv32_isa_pkg::LOAD || opcode == rv32_isa_pkg::STORE) begin
            state_q <= MEM_LO;
          end else if (opcode == rv32_isa_pkg::SYSTEM && ir_q[31:7] == '0) begin
            state_q <= HALT;
          end else begin
            state_q <= EXECUTE;
          end
        end
        MEM_LO:   if (done) state_q <= MEM_HI;
        MEM_HI:   if (done) state_q <= EXECUTE;
        EXECUTE: begin
          pc_q    <= next_pc;
          state_q <= FETCH_LO;
        end
        default:  state_q <= HALT;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (done) begin
      case (state_q)
        FETCH_LO: ir_q[15:0]    <= bus.rdata;
        FETCH_HI: ir_q[31:16]   <= bus.rdata;
        MEM_LO:   load_q[15:0]  <= bus.rdata;
        MEM_HI:   load_q[31:16] <= bus.rdata;
        default:  ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/rv32_mem_map.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_mem_map (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  mem_bus_if.slave                core,
  mem_bus_if.master               sram,
  output rv32_mem_map_pkg::half_t gpio_o
);

  rv32_mem_map_pkg::region_t region;
  rv32_mem_map_pkg::half_t   gpio_q;
  logic                      local_ack_q;

  // Offset compare keeps the SRAM window test valid for any base
  always_comb begin
    if ((core.addr - rv32_mem_map_pkg::SRAM_BASE) <=
        (rv32_mem_map_pkg::SRAM_END - rv32_mem_map_pkg::SRAM_BASE)) begin
      region = rv32_mem_map_pkg::REG_SRAM;
    end else if (core.addr == rv32_mem_map_pkg::GPIO_ADDR) begin
      region = rv32_mem_map_pkg::REG_GPIO;
    end else begin
      region = rv32_mem_map_pkg::REG_NONE;
    end
  end

  // SRAM traffic goes straight through to the controller
  assign sram.req   = core.req && (region == rv32_mem_map_pkg::REG_SRAM);
  assign sram.we    = core.we;
  assign sram.addr  = core.addr;
  assign sram.wdata = core.wdata;

  assign core.ack   = sram.ack | local_ack_q;
  assign core.rdata = (region == rv32_mem_map_pkg::REG_SRAM) ? sram.rdata :
                      (region == rv32_mem_map_pkg::REG_GPIO) ? gpio_q : '0;
  assign gpio_o     = gpio_q;

  // GPIO and unmapped accesses answer one cycle after req
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      local_ack_q <= 1'b0;
      gpio_q      <= '0;
    end else begin
      local_ack_q <= core.req && (region != rv32_mem_map_pkg::REG_SRAM);
      if (core.req && core.we && !local_ack_q && region == rv32_mem_map_pkg::REG_GPIO) begin
        gpio_q <= core.wdata;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/sram16_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sram16_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  mem_bus_if.slave                bus,
  output rv32_mem_map_pkg::half_t sram_addr_o,
  output rv32_mem_map_pkg::half_t sram_data_o,
  input  rv32_mem_map_pkg::half_t sram_data_i,
  output logic                    sram_ce_n_o,
  output logic                    sram_oe_n_o,
  output logic                    sram_we_n_o
);

  typedef enum logic [1:0] {S_IDLE, S_ACCESS, S_ACK} state_t;

  state_t                  state_q;
  logic                    cnt_q;
  rv32_mem_map_pkg::half_t rdata_q;
  logic                    active;

  // Byte address to halfword index
  assign sram_addr_o = bus.addr[16:1];
  assign sram_data_o = bus.wdata;

  assign active      = (state_q == S_ACCESS);
  assign sram_ce_n_o = !active;
  assign sram_oe_n_o = !(active && !bus.we);
  assign sram_we_n_o = !(active && bus.we);

  assign bus.ack   = (state_q == S_ACK);
  assign bus.rdata = rdata_q;

  // Strobes stay low for two cycles, ack follows on the third
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      cnt_q   <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (bus.req) begin
            state_q <= S_ACCESS;
            cnt_q   <= 1'b0;
          end
        end
        S_ACCESS: begin
          cnt_q <= 1'b1;
          if (cnt_q) state_q <= S_ACK;
        end
        S_ACK:   if (!bus.req) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (active && cnt_q) begin
      rdata_q <= sram_data_i;
    end
  end

endmodule

`default_nettype wire

/* logic/rv32_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_soc (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  output rv32_mem_map_pkg::half_t sram_addr_o,
  output rv32_mem_map_pkg::half_t sram_data_o,
  input  rv32_mem_map_pkg::half_t sram_data_i,
  output logic                    sram_ce_n_o,
  output logic                    sram_oe_n_o,
  output logic                    sram_we_n_o,
  output rv32_mem_map_pkg::half_t gpio_o,
  output logic                    halted_o
);

  rv32_isa_pkg::reg_addr_t rs1_addr;
  rv32_isa_pkg::reg_addr_t rs2_addr;
  rv32_isa_pkg::reg_addr_t rd_addr;
  logic                    rd_we;
  rv32_isa_pkg::xlen_t     rd_data;
  rv32_isa_pkg::xlen_t     rs1;
  rv32_isa_pkg::xlen_t     rs2;
  rv32_isa_pkg::alu_op_t   alu_op;
  rv32_isa_pkg::xlen_t     alu_b;
  rv32_isa_pkg::xlen_t     alu_result;
  logic                    alu_equal;
  logic                    alu_less;
  logic                    alu_less_signed;

  mem_bus_if core_bus ();
  mem_bus_if sram_bus ();

  //////////////////////////////////////////////////////////////////////
  // Core

  rv32_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .we_i       (rd_we),
    .rd_addr_i  (rd_addr),
    .rd_data_i  (rd_data),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_o      (rs1),
    .rs2_o      (rs2)
  );

  // Operand A is always rs1
  rv32_alu u_alu (
    .op_i          (alu_op),
    .a_i           (rs1),
    .b_i           (alu_b),
    .result_o      (alu_result),
    .equal_o       (alu_equal),
    .less_o        (alu_less),
    .less_signed_o (alu_less_signed)
  );

  rv32_control u_control (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .bus               (core_bus.master),
    .rs1_addr_o        (rs1_addr),
    .rs2_addr_o        (rs2_addr),
    .rd_addr_o         (rd_addr),
    .rd_we_o           (rd_we),
    .rd_data_o         (rd_data),
    .rs1_i             (rs1),
    .rs2_i             (rs2),
    .alu_op_o          (alu_op),
    .alu_b_o           (alu_b),
    .alu_result_i      (alu_result),
    .alu_equal_i       (alu_equal),
    .alu_less_i        (alu_less),
    .alu_less_signed_i (alu_less_signed),
    .halted_o          (halted_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory map and external SRAM

  rv32_mem_map u_mem_map (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .core    (core_bus.slave),
    .sram    (sram_bus.master),
    .gpio_o  (gpio_o)
  );

  sram16_ctrl u_sram16_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (sram_bus.slave),
    .sram_addr_o (sram_addr_o),
    .sram_data_o (sram_data_o),
    .sram_data_i (sram_data_i),
    .sram_ce_n_o (sram_ce_n_o),
    .sram_oe_n_o (sram_oe_n_o),
    .sram_we_n_o (sram_we_n_o)
  );

endmodule

`default_nettype wire

/* sim/rv32_soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_soc_tb;

  // Stored words land in slots of this area, one slot per register index
  localparam logic [31:0] DATA_BASE = 32'h0000_0400;
  localparam int          SLOTS     = 19;

  logic                    clk_i;
  logic                    rst_n_i;
  rv32_mem_map_pkg::half_t sram_addr_o;
  rv32_mem_map_pkg::half_t sram_data_o;
  rv32_mem_map_pkg::half_t sram_data_i;
  logic                    sram_ce_n_o;
  logic                    sram_oe_n_o;
  logic                    sram_we_n_o;
  rv32_mem_map_pkg::half_t gpio_o;
  logic                    halted_o;

  logic [15:0] mem [65536];
  logic [31:0] prog [$];
  logic [31:0] mregs [32];
  logic [31:0] exp_data [SLOTS];
  logic [15:0] exp_gpio;
  logic [31:0] jal_pc;
  int          reload_slot;
  int          n_exec;
  int          limit;
  int          cycles;
  int          seed = 32'h53497e54;
  int          errors = 0;
  int          checks = 0;

  rv32_soc u_rv32_soc (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sram_addr_o (sram_addr_o),
    .sram_data_o (sram_data_o),
    .sram_data_i (sram_data_i),
    .sram_ce_n_o (sram_ce_n_o),
    .sram_oe_n_o (sram_oe_n_o),
    .sram_we_n_o (sram_we_n_o),
    .gpio_o      (gpio_o),
    .halted_o    (halted_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Asynchronous SRAM model

  assign sram_data_i = (!sram_ce_n_o && !sram_oe_n_o) ? mem[sram_addr_o] : 16'h0000;

  always @(posedge clk_i) begin
    if (!sram_ce_n_o && !sram_we_n_o) begin
      mem[sram_addr_o] <= sram_data_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction encoders and helpers

  function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic sub,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return a + b;
    endcase
  endfunction

  function automatic logic [31:0] stored_word(input int slot);
    logic [15:0] h;
    h = 16'((DATA_BASE + 32'(4 * slot)) >> 1);
    return {mem[h + 16'd1], mem[h]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("error: %s got %h expected %h", name, got, exp);
        errors++;
      end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Program generation and reference model

  task automatic build_program();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3_tab [7];
    int         pick;
    f3_tab = '{3'b000, 3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
    for (int i = 1; i < 16; i++) begin
      prog.push_back(u_format(20'(rand_below(32'h0010_0000)), 5'(i)));
      prog.push_back(i_format(12'(rand_below(4096)), 5'(i), 3'b000, 5'(i),
                              rv32_isa_pkg::OP_IMM));
    end
    for (int k = 0; k < 40; k++) begin
      rd  = 5'(1 + rand_below(15));
      rs1 = 5'(1 + rand_below(15));
      rs2 = 5'(1 + rand_below(15));
      if (rand_below(2) == 0) begin
        // Index 1 selects SUB
        pick = int'(rand_below(7));
        prog.push_back(r_format((pick == 1) ? 7'h20 : 7'h00, rs2, rs1, f3_tab[pick], rd));
      end else begin
        pick = int'(1 + rand_below(6));
        prog.push_back(i_format(12'(rand_below(4096)), rs1, f3_tab[pick], rd,
                                rv32_isa_pkg::OP_IMM));
      end
    end
    // With x16 at 1 every branch form below is taken
    prog.push_back(i_format(12'd1, 5'd0, 3'b000, 5'd16, rv32_isa_pkg::OP_IMM));
    case (rand_below(4))
      0:       prog.push_back(b_format(13'd8, 5'd16, 5'd16, rv32_isa_pkg::F3_BEQ));
      1:       prog.push_back(b_format(13'd8, 5'd0, 5'd16, rv32_isa_pkg::F3_BNE));
      2:       prog.push_back(b_format(13'd8, 5'd16, 5'd0, rv32_isa_pkg::F3_BLT));
      default: prog.push_back(b_format(13'd8, 5'd0, 5'd16, rv32_isa_pkg::F3_BGE));
    endcase
    prog.push_back(i_format(12'hfff, 5'd0, 3'b000, 5'(1 + rand_below(15)),
                            rv32_isa_pkg::OP_IMM));
    jal_pc = 32'(prog.size()) * 32'd4;
    prog.push_back(j_format(21'd8, 5'd17));
    prog.push_back(i_format(12'h555, 5'd0, 3'b000, 5'(1 + rand_below(15)),
                            rv32_isa_pkg::OP_IMM));
    for (int i = 1; i < 18; i++) begin
      prog.push_back(s_format(12'(DATA_BASE + 32'(4 * i)), 5'(i), 5'd0));
    end
    reload_slot = int'(1 + rand_below(17));
    prog.push_back(i_format(12'(DATA_BASE + 32'(4 * reload_slot)), 5'd0, 3'b010, 5'd18,
                            rv32_isa_pkg::LOAD));
    prog.push_back(s_format(12'(DATA_BASE + 32'd72), 5'd18, 5'd0));
    prog.push_back(u_format(rv32_mem_map_pkg::GPIO_ADDR[31:12], 5'd19));
    prog.push_back(s_format(12'd0, 5'(1 + rand_below(15)), 5'd19));
    prog.push_back(32'h0000_0073);
  endtask

  task automatic run_reference();
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] wb;
    logic        wb_en;
    logic        taken;
    logic        halt;
    pc = '0;
    halt = 1'b0;
    n_exec = 0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    while (!halt && n_exec < 1000) begin
      inst    = prog[pc[31:2]];
      a       = mregs[inst[19:15]];
      b       = mregs[inst[24:20]];
      imm_i   = {{20{inst[31]}}, inst[31:20]};
      next_pc = pc + 32'd4;
      wb_en   = 1'b1;
      wb      = '0;
      case (inst[6:0])
        rv32_isa_pkg::OP:     wb = alu_result(inst[14:12], inst[30], a, b);
        rv32_isa_pkg::OP_IMM: wb = alu_result(inst[14:12], 1'b0, a, imm_i);
        rv32_isa_pkg::LUI:    wb = {inst[31:12], 12'h000};
        rv32_isa_pkg::LOAD:   wb = exp_data[(a + imm_i - DATA_BASE) >> 2];
        rv32_isa_pkg::STORE: begin
          wb_en = 1'b0;
          addr  = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          if (addr == rv32_mem_map_pkg::GPIO_ADDR) begin
            exp_gpio = b[15:0];
          end else begin
            exp_data[(addr - DATA_BASE) >> 2] = b;
          end
        end
        rv32_isa_pkg::BRANCH: begin
          wb_en = 1'b0;
          case (inst[14:12])
            rv32_isa_pkg::F3_BEQ: taken = (a == b);
            rv32_isa_pkg::F3_BNE: taken = (a != b);
            rv32_isa_pkg::F3_BLT: taken = ($signed(a) < $signed(b));
            default:              taken = ($signed(a) >= $signed(b));
          endcase
          if (taken) begin
            next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
          end
        end
        rv32_isa_pkg::JAL: begin
          wb      = pc + 32'd4;
          next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        rv32_isa_pkg::SYSTEM: begin
          wb_en = 1'b0;
          halt  = 1'b1;
        end
        default: wb_en = 1'b0;
      endcase
      if (wb_en && inst[11:7] != '0) begin
        mregs[inst[11:7]] = wb;
      end
      pc = next_pc;
      n_exec++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    rst_n_i = 1'b0;
    exp_gpio = '0;
    for (int s = 0; s < SLOTS; s++) begin
      exp_data[s] = '0;
    end
    build_program();
    run_reference();
    limit = 40 * n_exec + 200;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 16'(i) ^ 16'h5a3c;
    end
    foreach (prog[i]) begin
      mem[2 * i]     = prog[i][15:0];
      mem[2 * i + 1] = prog[i][31:16];
    end
    repeat (5) @(posedge clk_i);
    #1;
    check_value("sram_ce_n_o", 32'(sram_ce_n_o), 32'd1);
    check_value("sram_oe_n_o", 32'(sram_oe_n_o), 32'd1);
    check_value("sram_we_n_o", 32'(sram_we_n_o), 32'd1);
    check_value("gpio_o", 32'(gpio_o), 32'd0);
    check_value("halted_o", 32'(halted_o), 32'd0);
    rst_n_i = 1'b1;
    cycles = 0;
    while (!halted_o && cycles < limit) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!halted_o) begin
      $display("timeout: halted_o did not rise within %0d cycles", limit);
      $display("TESTS FAILED");
      $finish;
    end else begin
      // The core is halted, so no further SRAM write may start
      repeat (50) begin
        @(posedge clk_i);
        #1;
        check_value("halted_o", 32'(halted_o), 32'd1);
        check_value("sram_we_n_o", 32'(sram_we_n_o), 32'd1);
      end
      for (int s = 1; s < SLOTS; s++) begin
        check_value($sformatf("sram data word x%0d", s), stored_word(s), exp_data[s]);
      end
      check_value("reloaded word x18", stored_word(18), exp_data[reload_slot]);
      check_value("link register x17", stored_word(17), jal_pc + 32'd4);
      check_value("gpio_o", 32'(gpio_o), 32'(exp_gpio));
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* rv32_soc.f */
logic/rv32_isa_pkg.sv
logic/rv32_mem_map_pkg.sv
logic/mem_bus_if.sv
logic/rv32_regfile.sv
logic/rv32_alu.sv
logic/rv32_control.sv
logic/rv32_mem_map.sv
logic/sram16_ctrl.sv
logic/rv32_soc.sv
sim/rv32_soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv32_soc_tb
FILELIST  ?= rv32_soc.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run passes only when the pass message appears in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
